// File: rtl/iw_pkg.sv
`default_nettype none

package iw_pkg;

    // field widths
    localparam int vreg_w = 5;
    localparam int ctx_w  = 3;
    localparam int word_w = 32;

    // which execute unit takes the instruction
    typedef enum logic [1:0] {
        exec_alu,
        exec_load,
        exec_store,
        exec_branch
    } exec_t;

    // branch view of the payload word
    // both contexts in the low bits with unused padding above
    typedef struct packed {
        logic [word_w-2*ctx_w-1:0] pad;
        logic [ctx_w-1:0]          b_t_context;
        logic [ctx_w-1:0]          b_f_context;
    } iw_branch_t;

    // imm view for alu/load/store and branch view for exec_branch
    typedef union packed {
        logic [word_w-1:0] imm;
        iw_branch_t        branch;
    } iw_payload_u;

    // configuration register map
    typedef enum logic [1:0] {
        cfg_ctrl,
        cfg_flush,
        cfg_count
    } cfg_addr_t;

endpackage

`default_nettype wire

// File: rtl/reg_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module reg_scoreboard #(
    parameter int num_vregs = 32
) (
    input  logic                      clk,
    input  logic                      rst,

    // mark a new pending write
    input  logic                      set_valid,
    input  logic [iw_pkg::vreg_w-1:0] set_vreg,

    // dispatch queries
    input  logic [iw_pkg::vreg_w-1:0] rs1_q,
    input  logic [iw_pkg::vreg_w-1:0] rs2_q,
    input  logic [iw_pkg::vreg_w-1:0] rd_q,

    // writeback
    input  logic                      wb_valid,
    input  logic [iw_pkg::vreg_w-1:0] wb_vreg,

    output logic                      rs1_pend,
    output logic                      rs2_pend,
    output logic                      rd_pend
);
    import iw_pkg::*;

    logic [num_vregs-1:0] pend;
    logic [num_vregs-1:0] clr_hit;
    logic [num_vregs-1:0] set_hit;

    // one-hot decode of both update ports
    always_comb begin
        for (int v = 0; v < num_vregs; v++) begin
            clr_hit[v] = wb_valid && (wb_vreg == vreg_w'(v));
            set_hit[v] = set_valid && (set_vreg == vreg_w'(v));
        end
    end

    // set wins over clear on the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= '0;
        end else begin
            pend <= (pend & ~clr_hit) | set_hit;
        end
    end

    // writeback in this cycle already counts as done
    assign rs1_pend = pend[rs1_q] && !(wb_valid && (wb_vreg == rs1_q));
    assign rs2_pend = pend[rs2_q] && !(wb_valid && (wb_vreg == rs2_q));
    assign rd_pend  = pend[rd_q]  && !(wb_valid && (wb_vreg == rd_q));

endmodule

`default_nettype wire

// File: rtl/inst_window.sv
`timescale 1ns/1ps
`default_nettype none

module inst_window #(
    parameter int window_size = 8,
    parameter int issue_span  = 4
) (
    input  logic                      clk,
    input  logic                      rst,

    // from decode
    input  logic                      d_done,
    input  iw_pkg::exec_t             d_exec_type,
    input  iw_pkg::iw_payload_u       d_payload,
    input  logic [iw_pkg::ctx_w-1:0]  d_context,
    input  logic                      d_rs1_used,
    input  logic [iw_pkg::vreg_w-1:0] d_rs1,
    input  logic                      d_rs2_used,
    input  logic [iw_pkg::vreg_w-1:0] d_rs2,
    input  logic                      d_rd_used,
    input  logic [iw_pkg::vreg_w-1:0] d_rd,
    output logic                      accept_able,

    // scoreboard
    input  logic                      rs1_pend,
    input  logic                      rs2_pend,
    input  logic                      rd_pend,
    output logic                      set_valid,

    // writeback
    input  logic                      wb_valid,
    input  logic [iw_pkg::vreg_w-1:0] wb_vreg,

    // execute
    output logic                      order,
    input  logic                      accepted,
    output iw_pkg::exec_t             o_exec_type,
    output iw_pkg::iw_payload_u       o_payload,
    output logic [iw_pkg::ctx_w-1:0]  o_context,
    output logic [iw_pkg::vreg_w-1:0] o_rd,

    // configuration
    input  logic                      issue_en,
    input  logic                      flush_valid,
    input  logic [iw_pkg::ctx_w-1:0]  flush_context
);
    import iw_pkg::*;

    localparam int idx_w = $clog2(window_size);
    localparam int cnt_w = $clog2(window_size + 1);

    // entry state with slot 0 the oldest
    logic [window_size-1:0] e_valid;
    exec_t                  e_exec    [window_size];
    iw_payload_u            e_payload [window_size];
    logic [ctx_w-1:0]       e_ctx     [window_size];
    logic [vreg_w-1:0]      e_rs1     [window_size];
    logic [vreg_w-1:0]      e_rs2     [window_size];
    logic [vreg_w-1:0]      e_rd      [window_size];
    logic [window_size-1:0] e_rs1_rdy;
    logic [window_size-1:0] e_rs2_rdy;
    logic [window_size-1:0] e_rd_rdy;

    // next state
    logic [window_size-1:0] n_valid;
    exec_t                  n_exec    [window_size];
    iw_payload_u            n_payload [window_size];
    logic [ctx_w-1:0]       n_ctx     [window_size];
    logic [vreg_w-1:0]      n_rs1     [window_size];
    logic [vreg_w-1:0]      n_rs2     [window_size];
    logic [vreg_w-1:0]      n_rd      [window_size];
    logic [window_size-1:0] n_rs1_rdy;
    logic [window_size-1:0] n_rs2_rdy;
    logic [window_size-1:0] n_rd_rdy;

    logic [window_size-1:0] all_rdy;
    logic [window_size-1:0] keep;
    logic [idx_w-1:0]       new_pos [window_size];
    logic [cnt_w-1:0]       num_keep;
    logic                   found;
    logic [idx_w-1:0]       pick_idx;
    logic [idx_w-1:0]       sel_idx;
    logic                   fire;
    logic                   d_take;

    // entry offered under back-pressure stays pinned until accepted
    logic                   held;
    logic [idx_w-1:0]       held_idx;

    assign all_rdy = e_valid & e_rs1_rdy & e_rs2_rdy & e_rd_rdy;

    // oldest ready entry inside the issue span
    always_comb begin
        found    = 1'b0;
        pick_idx = '0;
        for (int i = 0; i < issue_span; i++) begin
            if (all_rdy[i] && !found) begin
                found    = 1'b1;
                pick_idx = idx_w'(i);
            end
        end
    end

    assign sel_idx = held ? held_idx : pick_idx;
    assign order   = held || (issue_en && found);
    assign fire    = order && accepted;

    assign o_exec_type = e_exec[sel_idx];
    assign o_payload   = e_payload[sel_idx];
    assign o_context   = e_ctx[sel_idx];
    assign o_rd        = e_rd[sel_idx];

    // survivors and their compacted slots
    always_comb begin
        logic [cnt_w-1:0] pos;
        pos = '0;
        for (int i = 0; i < window_size; i++) begin
            keep[i] = e_valid[i]
                && !(flush_valid && (e_ctx[i] == flush_context))
                && !(fire && (sel_idx == idx_w'(i)));
            new_pos[i] = pos[idx_w-1:0];
            pos = pos + cnt_w'(keep[i]);
        end
        num_keep = pos;
    end

    // same-cycle flush also drops a dispatch of that context
    assign d_take      = d_done && !(flush_valid && (d_context == flush_context));
    assign accept_able = (num_keep < cnt_w'(window_size));
    assign set_valid   = d_done && d_rd_used;

    // shift survivors down and append the new instruction behind them
    always_comb begin
        for (int j = 0; j < window_size; j++) begin
            n_valid[j]   = 1'b0;
            n_exec[j]    = e_exec[j];
            n_payload[j] = e_payload[j];
            n_ctx[j]     = e_ctx[j];
            n_rs1[j]     = e_rs1[j];
            n_rs2[j]     = e_rs2[j];
            n_rd[j]      = e_rd[j];
            n_rs1_rdy[j] = e_rs1_rdy[j];
            n_rs2_rdy[j] = e_rs2_rdy[j];
            n_rd_rdy[j]  = e_rd_rdy[j];
            for (int i = 0; i < window_size; i++) begin
                if (keep[i] && (new_pos[i] == idx_w'(j))) begin
                    n_valid[j]   = 1'b1;
                    n_exec[j]    = e_exec[i];
                    n_payload[j] = e_payload[i];
                    n_ctx[j]     = e_ctx[i];
                    n_rs1[j]     = e_rs1[i];
                    n_rs2[j]     = e_rs2[i];
                    n_rd[j]      = e_rd[i];
                    // wakeup on writeback
                    n_rs1_rdy[j] = e_rs1_rdy[i] || (wb_valid && (wb_vreg == e_rs1[i]));
                    n_rs2_rdy[j] = e_rs2_rdy[i] || (wb_valid && (wb_vreg == e_rs2[i]));
                    n_rd_rdy[j]  = e_rd_rdy[i]  || (wb_valid && (wb_vreg == e_rd[i]));
                end
            end
            if (d_take && (num_keep == cnt_w'(j))) begin
                n_valid[j]   = 1'b1;
                n_exec[j]    = d_exec_type;
                n_payload[j] = d_payload;
                n_ctx[j]     = d_context;
                n_rs1[j]     = d_rs1;
                n_rs2[j]     = d_rs2;
                // unused rd reads back as zero
                n_rd[j]      = d_rd_used ? d_rd : '0;
                n_rs1_rdy[j] = !(d_rs1_used && rs1_pend);
                n_rs2_rdy[j] = !(d_rs2_used && rs2_pend);
                // wait for the older writer of rd (WAW)
                n_rd_rdy[j]  = !(d_rd_used && rd_pend);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid  <= '0;
            held     <= 1'b0;
            held_idx <= '0;
        end else begin
            e_valid  <= n_valid;
            held     <= order && !accepted && keep[sel_idx];
            held_idx <= new_pos[sel_idx];
        end
    end

    // entry fields and ready bits
    always_ff @(posedge clk) begin
        e_exec    <= n_exec;
        e_payload <= n_payload;
        e_ctx     <= n_ctx;
        e_rs1     <= n_rs1;
        e_rs2     <= n_rs2;
        e_rd      <= n_rd;
        e_rs1_rdy <= n_rs1_rdy;
        e_rs2_rdy <= n_rs2_rdy;
        e_rd_rdy  <= n_rd_rdy;
    end

endmodule

`default_nettype wire

// File: rtl/iw_config.sv
`timescale 1ns/1ps
`default_nettype none

module iw_config (
    input  logic                      clk,
    input  logic                      rst,

    // register bus
    input  logic                      cfg_we,
    input  iw_pkg::cfg_addr_t         cfg_addr,
    input  logic [iw_pkg::word_w-1:0] cfg_wdata,
    output logic [iw_pkg::word_w-1:0] cfg_rdata,

    // one instruction left for execute
    input  logic                      issued,

    output logic                      issue_en,
    output logic                      flush_valid,
    output logic [iw_pkg::ctx_w-1:0]  flush_context
);
    import iw_pkg::*;

    logic [word_w-1:0] issue_cnt;

    // ctrl bit 0 enables issue
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_en <= 1'b1;
        end else if (cfg_we && (cfg_addr == cfg_ctrl)) begin
            issue_en <= cfg_wdata[0];
        end
    end

    // flush write becomes a single-cycle kill
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_valid   <= 1'b0;
            flush_context <= '0;
        end else begin
            flush_valid <= cfg_we && (cfg_addr == cfg_flush);
            if (cfg_we && (cfg_addr == cfg_flush)) begin
                flush_context <= cfg_wdata[ctx_w-1:0];
            end
        end
    end

    // a bus write loads the counter and wins over an issue
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_cnt <= '0;
        end else if (cfg_we && (cfg_addr == cfg_count)) begin
            issue_cnt <= cfg_wdata;
        end else if (issued) begin
            issue_cnt <= issue_cnt + word_w'(1);
        end
    end

    always_comb begin
        case (cfg_addr)
            cfg_ctrl:  cfg_rdata = {{(word_w-1){1'b0}}, issue_en};
            cfg_flush: cfg_rdata = {{(word_w-ctx_w){1'b0}}, flush_context};
            cfg_count: cfg_rdata = issue_cnt;
            default:   cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/inst_window_top.sv
`timescale 1ns/1ps
`default_nettype none

module inst_window_top #(
    parameter int window_size = 8,
    parameter int issue_span  = 4,
    parameter int num_vregs   = 32
) (
    input  logic                      clk,
    input  logic                      rst,

    // decode
    input  logic                      d_done,
    input  iw_pkg::exec_t             d_exec_type,
    input  iw_pkg::iw_payload_u       d_payload,
    input  logic [iw_pkg::ctx_w-1:0]  d_context,
    input  logic                      d_rs1_used,
    input  logic [iw_pkg::vreg_w-1:0] d_rs1,
    input  logic                      d_rs2_used,
    input  logic [iw_pkg::vreg_w-1:0] d_rs2,
    input  logic                      d_rd_used,
    input  logic [iw_pkg::vreg_w-1:0] d_rd,
    output logic                      accept_able,

    // writeback
    input  logic                      wb_valid,
    input  logic [iw_pkg::vreg_w-1:0] wb_vreg,

    // execute
    output logic                      order,
    input  logic                      accepted,
    output iw_pkg::exec_t             o_exec_type,
    output iw_pkg::iw_payload_u       o_payload,
    output logic [iw_pkg::ctx_w-1:0]  o_context,
    output logic [iw_pkg::vreg_w-1:0] o_rd,

    // configuration bus
    input  logic                      cfg_we,
    input  iw_pkg::cfg_addr_t         cfg_addr,
    input  logic [iw_pkg::word_w-1:0] cfg_wdata,
    output logic [iw_pkg::word_w-1:0] cfg_rdata
);
    import iw_pkg::*;

    logic             rs1_pend;
    logic             rs2_pend;
    logic             rd_pend;
    logic             set_valid;
    logic             issue_en;
    logic             flush_valid;
    logic [ctx_w-1:0] flush_context;

    // rd of the dispatching instruction becomes pending
    reg_scoreboard #(
        .num_vregs (num_vregs)
    ) u_scoreboard (
        .clk       (clk),
        .rst       (rst),
        .set_valid (set_valid),
        .set_vreg  (d_rd),
        .rs1_q     (d_rs1),
        .rs2_q     (d_rs2),
        .rd_q      (d_rd),
        .wb_valid  (wb_valid),
        .wb_vreg   (wb_vreg),
        .rs1_pend  (rs1_pend),
        .rs2_pend  (rs2_pend),
        .rd_pend   (rd_pend)
    );

    inst_window #(
        .window_size (window_size),
        .issue_span  (issue_span)
    ) u_window (
        .clk           (clk),
        .rst           (rst),
        .d_done        (d_done),
        .d_exec_type   (d_exec_type),
        .d_payload     (d_payload),
        .d_context     (d_context),
        .d_rs1_used    (d_rs1_used),
        .d_rs1         (d_rs1),
        .d_rs2_used    (d_rs2_used),
        .d_rs2         (d_rs2),
        .d_rd_used     (d_rd_used),
        .d_rd          (d_rd),
        .accept_able   (accept_able),
        .rs1_pend      (rs1_pend),
        .rs2_pend      (rs2_pend),
        .rd_pend       (rd_pend),
        .set_valid     (set_valid),
        .wb_valid      (wb_valid),
        .wb_vreg       (wb_vreg),
        .order         (order),
        .accepted      (accepted),
        .o_exec_type   (o_exec_type),
        .o_payload     (o_payload),
        .o_context     (o_context),
        .o_rd          (o_rd),
        .issue_en      (issue_en),
        .flush_valid   (flush_valid),
        .flush_context (flush_context)
    );

    iw_config u_config (
        .clk           (clk),
        .rst           (rst),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .issued        (order & accepted),
        .issue_en      (issue_en),
        .flush_valid   (flush_valid),
        .flush_context (flush_context)
    );

endmodule

`default_nettype wire

// File: test/inst_window_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module inst_window_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      d_done,
    input logic                      accept_able,
    input logic                      order,
    input logic                      accepted,
    input logic                      flush_valid,
    input iw_pkg::exec_t             o_exec_type,
    input iw_pkg::iw_payload_u       o_payload,
    input logic [iw_pkg::ctx_w-1:0]  o_context,
    input logic [iw_pkg::vreg_w-1:0] o_rd
);

    // quiet once reset has been seen for a full cycle
    reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !order && !flush_valid)
        else $error("order or flush_valid high during reset");

    // a flush may legally remove the offered entry
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        order && !accepted && !flush_valid |=> order && $stable(o_rd)
            && $stable(o_context) && $stable(o_exec_type) && $stable(o_payload))
        else $error("execute outputs changed under back-pressure");

    no_overfill: assert property (@(posedge clk) disable iff (rst)
        d_done |-> accept_able)
        else $error("dispatch while the window could not accept");

endmodule

bind inst_window_top inst_window_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .d_done      (d_done),
    .accept_able (accept_able),
    .order       (order),
    .accepted    (accepted),
    .flush_valid (flush_valid),
    .o_exec_type (o_exec_type),
    .o_payload   (o_payload),
    .o_context   (o_context),
    .o_rd        (o_rd)
);

`default_nettype wire

// File: test/tb_inst_window.sv
`timescale 1ns/1ps
`default_nettype none

module tb_inst_window;
    import iw_pkg::*;

    // one cycle of stimulus and what execute should see in it
    typedef struct {
        int test;
        bit dsp;
        int ctx;
        int rs1;
        int rs2;
        int rd;
        int wb;
        bit acc;
        int cfg;
        int src;
        int aa;
    } row_t;

    logic              clk;
    logic              rst;
    logic              d_done;
    exec_t             d_exec_type;
    iw_payload_u       d_payload;
    logic [ctx_w-1:0]  d_context;
    logic              d_rs1_used;
    logic [vreg_w-1:0] d_rs1;
    logic              d_rs2_used;
    logic [vreg_w-1:0] d_rs2;
    logic              d_rd_used;
    logic [vreg_w-1:0] d_rd;
    logic              accept_able;
    logic              wb_valid;
    logic [vreg_w-1:0] wb_vreg;
    logic              order;
    logic              accepted;
    exec_t             o_exec_type;
    iw_payload_u       o_payload;
    logic [ctx_w-1:0]  o_context;
    logic [vreg_w-1:0] o_rd;
    logic              cfg_we;
    cfg_addr_t         cfg_addr;
    logic [word_w-1:0] cfg_wdata;
    logic [word_w-1:0] cfg_rdata;

    row_t        tbl[$];
    logic [31:0] pay[$];
    logic [31:0] lfsr;
    string       names[7];
    int          test_err[7];
    int          errors;
    int          checks;
    int          cur_test;
    int          cycles;
    int          limit = 0;

    inst_window_top #(
        .window_size (8),
        .issue_span  (4),
        .num_vregs   (32)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("run stopped after %0d cycles without reaching the end", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic add_row(input int test, input bit dsp, input int ctx, input int rs1,
                           input int rs2, input int rd, input int wb, input bit acc,
                           input int cfg, input int src, input int aa);
        row_t        rw;
        logic [31:0] w;
        rw = '{test, dsp, ctx, rs1, rs2, rd, wb, acc, cfg, src, aa};
        w = '0;
        if (dsp) begin
            draw_word(w);
        end
        tbl.push_back(rw);
        pay.push_back(w);
    endtask

    // test, dsp, ctx, rs1, rs2, rd, wb, acc, cfg, src, aa
    // -1 is none or unchecked
    // cfg 0/1 writes ctrl and cfg 8+c flushes context c
    // src is the row whose instruction execute should be offered
    task automatic build_table();
        add_row(1, 1, 0, -1, -1,  1, -1, 0, -1, -1,  1);
        add_row(1, 1, 3, -1, -1,  2, -1, 1, -1,  0,  1);
        add_row(1, 1, 5, -1, -1,  3, -1, 1, -1,  1,  1);
        add_row(1, 0, 0, -1, -1, -1, -1, 1, -1,  2, -1);
        add_row(1, 0, 0, -1, -1, -1, -1, 0, -1, -1,  1);
        // consumer of vreg 4 waits for its writeback
        add_row(2, 1, 0, -1, -1,  4, -1, 0, -1, -1, -1);
        add_row(2, 1, 0,  4, -1,  5, -1, 1, -1,  5, -1);
        add_row(2, 0, 0, -1, -1, -1, -1, 1, -1, -1, -1);
        add_row(2, 0, 0, -1, -1, -1, -1, 1, -1, -1, -1);
        add_row(2, 0, 0, -1, -1, -1,  4, 1, -1, -1, -1);
        add_row(2, 0, 0, -1, -1, -1, -1, 1, -1,  6, -1);
        add_row(2, 0, 0, -1, -1, -1, -1, 0, -1, -1,  1);
        // younger entry passes the blocked one
        add_row(3, 1, 2, -1, -1,  6, -1, 0, -1, -1, -1);
        add_row(3, 1, 2,  6, -1,  7, -1, 1, -1, 12, -1);
        add_row(3, 1, 2, -1, -1,  8, -1, 0, -1, -1, -1);
        add_row(3, 0, 0, -1, -1, -1, -1, 1, -1, 14, -1);
        add_row(3, 1, 2, -1,  4,  9,  6, 0, -1, -1, -1);
        add_row(3, 0, 0, -1, -1, -1, -1, 1, -1, 13, -1);
        add_row(3, 0, 0, -1, -1, -1, -1, 1, -1, 16, -1);
        add_row(3, 0, 0, -1, -1, -1, -1, 0, -1, -1,  1);
        // held entry stays offered while an older one wakes
        // issue is then disabled for a while
        add_row(4, 1, 4,  8, -1, 10, -1, 0, -1, -1, -1);
        add_row(4, 1, 4, -1, -1, 11, -1, 0, -1, -1, -1);
        add_row(4, 0, 0, -1, -1, -1,  8, 0, -1, 21, -1);
        add_row(4, 0, 0, -1, -1, -1, -1, 1,  0, 21, -1);
        add_row(4, 0, 0, -1, -1, -1, -1, 1, -1, -1, -1);
        add_row(4, 1, 4, -1, -1, 12, -1, 1, -1, -1, -1);
        add_row(4, 0, 0, -1, -1, -1, -1, 1,  1, -1, -1);
        add_row(4, 0, 0, -1, -1, -1, -1, 1, -1, 20, -1);
        add_row(4, 0, 0, -1, -1, -1, -1, 1, -1, 25, -1);
        add_row(4, 0, 0, -1, -1, -1, -1, 0, -1, -1,  1);
        // context 1 is killed together with the row 34 dispatch
        add_row(5, 1, 1, -1, -1, 14, -1, 0,  0, -1, -1);
        add_row(5, 1, 2, -1, -1, 15, -1, 0, -1, -1, -1);
        add_row(5, 1, 1, -1, -1, 16, -1, 0, -1, -1, -1);
        add_row(5, 1, 2, -1, -1, 17, -1, 0,  9, -1, -1);
        add_row(5, 1, 1, -1, -1, 18, -1, 0, -1, -1,  1);
        add_row(5, 0, 0, -1, -1, -1, -1, 0,  1, -1,  1);
        add_row(5, 0, 0, -1, -1, -1, -1, 1, -1, 31, -1);
        add_row(5, 0, 0, -1, -1, -1, -1, 1, -1, 33, -1);
        add_row(5, 0, 0, -1, -1, -1, -1, 1, -1, -1,  1);
        // fill all eight slots with issue off
        add_row(6, 1, 6, -1, -1, 19, -1, 0,  0, -1,  1);
        for (int k = 20; k <= 26; k++) begin
            add_row(6, 1, 6, -1, -1, k, -1, 0, -1, -1, 1);
        end
        add_row(6, 0, 0, -1, -1, -1, -1, 0,  1, -1,  0);
        add_row(6, 0, 0, -1, -1, -1, -1, 0, -1, 39,  0);
        add_row(6, 0, 0, -1, -1, -1, -1, 1, -1, 39,  1);
        add_row(6, 0, 0, -1, -1, -1, -1, 1, -1, 40,  1);
        add_row(6, 0, 0, -1, -1, -1, -1, 0, -1, 41,  1);
    endtask

    task automatic idle_inputs();
        d_done      = 1'b0;
        d_exec_type = exec_alu;
        d_payload   = '0;
        d_context   = '0;
        d_rs1_used  = 1'b0;
        d_rs1       = '0;
        d_rs2_used  = 1'b0;
        d_rs2       = '0;
        d_rd_used   = 1'b0;
        d_rd        = '0;
        wb_valid    = 1'b0;
        wb_vreg     = '0;
        accepted    = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = cfg_count;
        cfg_wdata   = '0;
    endtask

    task automatic drive_row(input int r);
        row_t rw;
        rw = tbl[r];
        idle_inputs();
        d_done        = rw.dsp;
        d_exec_type   = exec_t'(r[1:0]);
        d_payload.imm = pay[r];
        d_context     = rw.ctx[ctx_w-1:0];
        d_rs1_used    = (rw.rs1 >= 0);
        d_rs2_used    = (rw.rs2 >= 0);
        d_rd_used     = (rw.rd >= 0);
        if (rw.rs1 >= 0) begin
            d_rs1 = rw.rs1[vreg_w-1:0];
        end
        if (rw.rs2 >= 0) begin
            d_rs2 = rw.rs2[vreg_w-1:0];
        end
        if (rw.rd >= 0) begin
            d_rd = rw.rd[vreg_w-1:0];
        end
        if (rw.wb >= 0) begin
            wb_valid = 1'b1;
            wb_vreg  = rw.wb[vreg_w-1:0];
        end
        accepted = rw.acc;
        if (rw.cfg >= 8) begin
            cfg_we    = 1'b1;
            cfg_addr  = cfg_flush;
            cfg_wdata = 32'(rw.cfg - 8);
        end else if (rw.cfg >= 0) begin
            cfg_we    = 1'b1;
            cfg_addr  = cfg_ctrl;
            cfg_wdata = 32'(rw.cfg);
        end
    endtask

    task automatic check_val(input string name, input int r, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] row %0d %s: got %h, expected %h", r, name, got, exp);
            errors++;
            test_err[cur_test]++;
        end
    endtask

    task automatic check_row(input int r);
        row_t rw;
        row_t sr;
        rw = tbl[r];
        if (rw.src == -1) begin
            check_val("order", r, 32'(order), 32'h0);
        end else if (rw.src >= 0) begin
            sr = tbl[rw.src];
            check_val("order", r, 32'(order), 32'h1);
            check_val("o_rd", r, 32'(o_rd), 32'(sr.rd));
            check_val("o_context", r, 32'(o_context), 32'(sr.ctx));
            check_val("o_exec_type", r, 32'(o_exec_type), 32'(rw.src % 4));
            check_val("o_payload", r, o_payload.imm, pay[rw.src]);
        end
        if (rw.aa >= 0) begin
            check_val("accept_able", r, 32'(accept_able), 32'(rw.aa));
        end
    endtask

    task automatic report_test(input int t);
        if (test_err[t] == 0) begin
            $display("test %0d %s: ok", t + 1, names[t]);
        end else begin
            $display("test %0d %s: %0d errors", t + 1, names[t], test_err[t]);
        end
    endtask

    initial begin
        int exp_count;
        int passed;
        errors   = 0;
        checks   = 0;
        cur_test = 0;
        cycles   = 0;
        lfsr     = 32'ha814_dfaf;
        names    = '{"independent issue", "rd dependency", "blocked older entry",
                     "back-pressure and enable", "context flush", "full window",
                     "issue counter"};
        test_err = '{default: 0};
        idle_inputs();
        rst = 1'b1;
        build_table();
        limit = tbl.size() + 50;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < tbl.size(); r++) begin
            if (r > 0) begin
                @(posedge clk);
                #1;
            end
            if (tbl[r].test - 1 != cur_test) begin
                report_test(cur_test);
                cur_test = tbl[r].test - 1;
            end
            drive_row(r);
            #2;
            check_row(r);
        end
        report_test(cur_test);

        // counter reads back the accepted issues of the whole table
        @(posedge clk);
        #1;
        idle_inputs();
        exp_count = 0;
        foreach (tbl[r]) begin
            if (tbl[r].src >= 0 && tbl[r].acc) begin
                exp_count++;
            end
        end
        cur_test = 6;
        #2;
        check_val("cfg_rdata", tbl.size(), cfg_rdata, 32'(exp_count));
        report_test(6);

        passed = 0;
        for (int t = 0; t < 7; t++) begin
            if (test_err[t] == 0) begin
                passed++;
            end
        end
        $display("summary: 7 tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 passed, 7 - passed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rtl/iw_pkg.sv
rtl/reg_scoreboard.sv
rtl/inst_window.sv
rtl/iw_config.sv
rtl/inst_window_top.sv
test/inst_window_assertions.sv
test/tb_inst_window.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the instruction window testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f flist.f --top-module tb_inst_window \
    -o sim_inst_window > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_inst_window > sim.log 2>&1 \
    || echo "simulator exited with an error status" >> sim.log
cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log && exit 0 || exit 1
